/* Bender.yml */
package:
  name: loong_id

sources:
  - include_dirs:
      - .
    files:
      - loong_id_pkg.sv
      - inst_decoder.sv
      - regfile.sv
      - operand_forward.sv
      - branch_unit.sv
      - id_stage_ctrl.sv
      - id_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - id_stage_checker.sv
      - tb_id_stage.sv

/* branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loong_id_params.svh"

module branch_unit
    import loong_id_pkg::*;
(
    input  br_kind_t            br_kind,
    input  logic [`LA_XLEN-1:0] br_offs,
    input  logic [`LA_XLEN-1:0] pc,
    input  logic [`LA_XLEN-1:0] rj_value,
    input  logic [`LA_XLEN-1:0] rkd_value,
    output logic                is_branch,
    output logic                cond_taken,
    output logic [`LA_XLEN-1:0] target
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    assign is_branch = br_kind != BR_NONE;

    always_comb begin
        case (br_kind)
            BR_BEQ:  cond_taken = eq;
            BR_BNE:  cond_taken = !eq;
            BR_BLT:  cond_taken = lt;
            BR_BGE:  cond_taken = !lt;
            BR_BLTU: cond_taken = ltu;
            BR_BGEU: cond_taken = !ltu;
            BR_B, BR_BL, BR_JIRL: begin
                cond_taken = 1'b1; // unconditional
            end
            default: cond_taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target = ((br_kind == BR_JIRL) ? rj_value : pc) + br_offs;

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loong_id_params.svh"

module id_stage
    import loong_id_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      flush,
    input  logic      if_valid,
    input  if_id_t    if_id,
    output logic      allowin,
    input  logic      ex_allowin,
    output logic      ex_valid,
    output id_ex_t    id_ex,
    input  fwd_t      fwd_ex,
    input  fwd_t      fwd_mem,
    input  rf_write_t wb,
    output br_t       br
);

    logic [`LA_INST_W-1:0] inst;
    logic [`LA_XLEN-1:0]   pc;
    logic                  valid;
    logic                  stall;
    logic                  cond_taken;
    logic                  is_branch;
    logic                  br_taken;
    logic                  br_stall;
    logic [`LA_XLEN-1:0]   target;
    dec_t                  dec;
    logic [`LA_REG_AW-1:0] raddr1;
    logic [`LA_REG_AW-1:0] raddr2;
    logic [`LA_XLEN-1:0]   rdata1;
    logic [`LA_XLEN-1:0]   rdata2;
    logic [`LA_XLEN-1:0]   rj_value;
    logic [`LA_XLEN-1:0]   rkd_value;

    id_stage_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .flush      (flush),
        .if_valid   (if_valid),
        .if_id      (if_id),
        .allowin    (allowin),
        .ex_allowin (ex_allowin),
        .stall      (stall),
        .cond_taken (cond_taken),
        .is_branch  (is_branch),
        .inst       (inst),
        .pc         (pc),
        .valid      (valid),
        .ex_valid   (ex_valid),
        .br_taken   (br_taken),
        .br_stall   (br_stall)
    );

    inst_decoder u_dec (
        .inst (inst),
        .dec  (dec)
    );

    assign raddr1 = inst[9:5];
    assign raddr2 = dec.src2_is_rd ? inst[4:0] : inst[14:10]; // rd for stores and branches

    regfile u_rf (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (wb)
    );

    operand_forward u_fwd (
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .need_r1   (dec.need_r1),
        .need_r2   (dec.need_r2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .fwd_ex    (fwd_ex),
        .fwd_mem   (fwd_mem),
        .wb        (wb),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit u_br (
        .br_kind    (dec.br_kind),
        .br_offs    (dec.br_offs),
        .pc         (pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .is_branch  (is_branch),
        .cond_taken (cond_taken),
        .target     (target)
    );

    always_comb begin
        id_ex.alu_op       = dec.alu_op;
        id_ex.alu_src1     = dec.src1_is_pc ? pc : rj_value;
        id_ex.alu_src2     = dec.src2_is_imm ? dec.imm : rkd_value;
        id_ex.rkd_value    = rkd_value;
        id_ex.pc           = pc;
        id_ex.rf_we        = dec.rf_we & valid;
        id_ex.rf_waddr     = dec.dest;
        id_ex.mem_rd       = dec.mem_rd;
        id_ex.mem_we       = dec.mem_we;
        id_ex.mem_size     = dec.mem_size;
        id_ex.mem_unsigned = dec.mem_unsigned;
    end

    always_comb begin
        br.taken  = br_taken;
        br.target = target;
        br.stall  = br_stall;
    end

endmodule

`default_nettype wire

/* id_stage_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_checker
    import loong_id_pkg::*;
(
    input logic   clk,
    input logic   resetn,
    input logic   flush,
    input logic   ex_valid,
    input logic   ex_allowin,
    input logic   stall,
    input br_t    br,
    input id_ex_t id_ex
);

    int fail_cnt = 0; // read by the testbench at the end

    // stage comes out of reset empty
    a_reset_empty: assert property (@(posedge clk)
        $rose(resetn) |-> !ex_valid && !br.taken && !br.stall)
        else begin fail_cnt++; $error("stage not empty after reset"); end

    a_no_valid_in_stall: assert property (@(posedge clk) disable iff (!resetn)
        !(ex_valid && stall))
        else begin fail_cnt++; $error("ex_valid high during stall"); end

    a_taken_xor_stall: assert property (@(posedge clk) disable iff (!resetn)
        !(br.taken && br.stall))
        else begin fail_cnt++; $error("branch taken and stalled together"); end

    a_hold_payload: assert property (@(posedge clk) disable iff (!resetn)
        ex_valid && !ex_allowin && !flush |=> $stable(id_ex))
        else begin fail_cnt++; $error("payload changed under back-pressure"); end

endmodule

bind id_stage id_stage_checker u_chk (.*);

`default_nettype wire

/* id_stage_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loong_id_params.svh"

module id_stage_ctrl
    import loong_id_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  flush,
    input  logic                  if_valid,
    input  if_id_t                if_id,
    output logic                  allowin,
    input  logic                  ex_allowin,
    input  logic                  stall,
    input  logic                  cond_taken,
    input  logic                  is_branch,
    output logic [`LA_INST_W-1:0] inst,
    output logic [`LA_XLEN-1:0]   pc,
    output logic                  valid,
    output logic                  ex_valid,
    output logic                  br_taken,
    output logic                  br_stall
);

    if_id_t held;

    assign ex_valid = valid & ~stall;
    assign br_taken = ex_valid & cond_taken;
    assign br_stall = valid & stall & is_branch; // target not known yet

    // a leaving taken branch is covered by ex_valid & ex_allowin
    assign allowin = ~valid | (ex_valid & ex_allowin) | flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (flush || (br_taken && ex_allowin)) begin
            valid <= 1'b0; // drop the wrong-path fetch
        end else if (allowin) begin
            valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && allowin) begin
            held <= if_id;
        end
    end

    assign inst = held.inst;
    assign pc   = held.pc;

endmodule

`default_nettype wire

/* inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loong_id_params.svh"

module inst_decoder
    import loong_id_pkg::*;
(
    input  logic [`LA_INST_W-1:0] inst,
    output dec_t                  dec
);

    logic [5:0]  op6;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [4:0]  rd;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic i_add, i_sub, i_slt, i_sltu, i_nor, i_and, i_or, i_xor;
    logic i_sll, i_srl, i_sra, i_slli, i_srli, i_srai;
    logic i_addi, i_slti, i_sltui, i_andi, i_ori, i_xori;
    logic i_lu12i, i_pcaddu12i;
    logic i_ld_b, i_ld_h, i_ld_w, i_ld_bu, i_ld_hu, i_st_b, i_st_h, i_st_w;
    logic i_jirl, i_b, i_bl, i_beq, i_bne, i_blt, i_bge, i_bltu, i_bgeu;
    logic rr_op, ui5_op, si12_op, ui12_op, si20_op, is_ld, is_st, cond_br, link;

    assign op6  = inst[31:26];
    assign op10 = inst[31:22];
    assign op7  = inst[21:15];
    assign rd   = inst[4:0];
    assign i12  = inst[21:10];
    assign i16  = inst[25:10];
    assign i20  = inst[24:5];
    assign i26  = {inst[9:0], inst[25:10]};

    // 3R group, op10 = 0 and op7 = {01, func}
    assign i_add  = op10 == 10'h000 && op7 == 7'h20;
    assign i_sub  = op10 == 10'h000 && op7 == 7'h22;
    assign i_slt  = op10 == 10'h000 && op7 == 7'h24;
    assign i_sltu = op10 == 10'h000 && op7 == 7'h25;
    assign i_nor  = op10 == 10'h000 && op7 == 7'h28;
    assign i_and  = op10 == 10'h000 && op7 == 7'h29;
    assign i_or   = op10 == 10'h000 && op7 == 7'h2a;
    assign i_xor  = op10 == 10'h000 && op7 == 7'h2b;
    assign i_sll  = op10 == 10'h000 && op7 == 7'h2e;
    assign i_srl  = op10 == 10'h000 && op7 == 7'h2f;
    assign i_sra  = op10 == 10'h000 && op7 == 7'h30;
    assign i_slli = op10 == 10'h001 && op7 == 7'h01;
    assign i_srli = op10 == 10'h001 && op7 == 7'h09;
    assign i_srai = op10 == 10'h001 && op7 == 7'h11;

    assign i_slti  = op10 == 10'h008;
    assign i_sltui = op10 == 10'h009;
    assign i_addi  = op10 == 10'h00a;
    assign i_andi  = op10 == 10'h00d;
    assign i_ori   = op10 == 10'h00e;
    assign i_xori  = op10 == 10'h00f;

    assign i_lu12i     = inst[31:25] == 7'b0001010;
    assign i_pcaddu12i = inst[31:25] == 7'b0001110;

    assign i_ld_b  = op10 == 10'h0a0;
    assign i_ld_h  = op10 == 10'h0a1;
    assign i_ld_w  = op10 == 10'h0a2;
    assign i_st_b  = op10 == 10'h0a4;
    assign i_st_h  = op10 == 10'h0a5;
    assign i_st_w  = op10 == 10'h0a6;
    assign i_ld_bu = op10 == 10'h0a8;
    assign i_ld_hu = op10 == 10'h0a9;

    assign i_jirl = op6 == 6'h13;
    assign i_b    = op6 == 6'h14;
    assign i_bl   = op6 == 6'h15;
    assign i_beq  = op6 == 6'h16;
    assign i_bne  = op6 == 6'h17;
    assign i_blt  = op6 == 6'h18;
    assign i_bge  = op6 == 6'h19;
    assign i_bltu = op6 == 6'h1a;
    assign i_bgeu = op6 == 6'h1b;

    assign rr_op   = i_add | i_sub | i_slt | i_sltu | i_nor | i_and | i_or | i_xor
                   | i_sll | i_srl | i_sra;
    assign ui5_op  = i_slli | i_srli | i_srai;
    assign si12_op = i_addi | i_slti | i_sltui;
    assign ui12_op = i_andi | i_ori | i_xori;
    assign si20_op = i_lu12i | i_pcaddu12i;
    assign is_ld   = i_ld_b | i_ld_h | i_ld_w | i_ld_bu | i_ld_hu;
    assign is_st   = i_st_b | i_st_h | i_st_w;
    assign cond_br = i_beq | i_bne | i_blt | i_bge | i_bltu | i_bgeu;
    assign link    = i_bl | i_jirl; // writes pc + 4

    always_comb begin
        dec = '0;

        dec.alu_op[ALU_ADD]  = i_add | i_addi | is_ld | is_st | link | i_pcaddu12i;
        dec.alu_op[ALU_SUB]  = i_sub;
        dec.alu_op[ALU_SLT]  = i_slt | i_slti;
        dec.alu_op[ALU_SLTU] = i_sltu | i_sltui;
        dec.alu_op[ALU_AND]  = i_and | i_andi;
        dec.alu_op[ALU_NOR]  = i_nor;
        dec.alu_op[ALU_OR]   = i_or | i_ori;
        dec.alu_op[ALU_XOR]  = i_xor | i_xori;
        dec.alu_op[ALU_SLL]  = i_sll | i_slli;
        dec.alu_op[ALU_SRL]  = i_srl | i_srli;
        dec.alu_op[ALU_SRA]  = i_sra | i_srai;
        dec.alu_op[ALU_LUI]  = i_lu12i;

        dec.src1_is_pc  = i_pcaddu12i | link;
        dec.src2_is_imm = ui5_op | si12_op | ui12_op | si20_op | is_ld | is_st | link;

        if (link) begin
            dec.imm = `LA_XLEN'd4;
        end else if (si20_op) begin
            dec.imm = {i20, 12'b0};
        end else if (ui5_op | si12_op | is_ld | is_st) begin
            dec.imm = {{(`LA_XLEN-12){i12[11]}}, i12}; // ui5 lives in the low bits
        end else begin
            dec.imm = {{(`LA_XLEN-12){1'b0}}, i12};
        end

        dec.br_kind = i_beq  ? BR_BEQ  :
                      i_bne  ? BR_BNE  :
                      i_blt  ? BR_BLT  :
                      i_bge  ? BR_BGE  :
                      i_bltu ? BR_BLTU :
                      i_bgeu ? BR_BGEU :
                      i_b    ? BR_B    :
                      i_bl   ? BR_BL   :
                      i_jirl ? BR_JIRL : BR_NONE;
        dec.br_offs = (i_b | i_bl) ? {{(`LA_XLEN-28){i26[25]}}, i26, 2'b00}
                                   : {{(`LA_XLEN-18){i16[15]}}, i16, 2'b00};

        dec.need_r1    = rr_op | ui5_op | si12_op | ui12_op | is_ld | is_st | cond_br | i_jirl;
        dec.need_r2    = rr_op | is_st | cond_br;
        dec.src2_is_rd = is_st | cond_br;

        dec.rf_we = rr_op | ui5_op | si12_op | ui12_op | si20_op | is_ld | link;
        dec.dest  = i_bl ? `LA_REG_AW'd1 : rd;

        dec.mem_rd       = is_ld;
        dec.mem_we       = is_st;
        dec.mem_size     = (i_ld_b | i_ld_bu | i_st_b) ? MEM_B :
                           (i_ld_h | i_ld_hu | i_st_h) ? MEM_H : MEM_W;
        dec.mem_unsigned = i_ld_bu | i_ld_hu;
    end

endmodule

`default_nettype wire

/* loong_id.f */
+incdir+.
loong_id_pkg.sv
inst_decoder.sv
regfile.sv
operand_forward.sv
branch_unit.sv
id_stage_ctrl.sv
id_stage.sv
id_stage_checker.sv
tb_id_stage.sv

/* loong_id_params.svh */
`ifndef LOONG_ID_PARAMS_SVH
`define LOONG_ID_PARAMS_SVH

// datapath and pc width
`define LA_XLEN 32

`define LA_INST_W 32

// architectural register file
`define LA_NREG 32
`define LA_REG_AW 5

// one-hot alu op vector
`define LA_ALU_OPS 12

`endif

/* loong_id_pkg.sv */
`default_nettype none

`include "loong_id_params.svh"

package loong_id_pkg;

    typedef logic [`LA_ALU_OPS-1:0] alu_op_t;

    // bit positions in alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef enum logic [1:0] {
        MEM_B = 2'd0,
        MEM_H = 2'd1,
        MEM_W = 2'd2
    } mem_size_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_kind_t;

    typedef struct packed {
        logic [`LA_INST_W-1:0] inst;
        logic [`LA_XLEN-1:0]   pc;
    } if_id_t;

    typedef struct packed {
        logic                  we;
        logic [`LA_REG_AW-1:0] waddr;
        logic [`LA_XLEN-1:0]   wdata;
    } rf_write_t;

    typedef struct packed {
        rf_write_t wr;
        logic      late; // value not produced yet
    } fwd_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic [`LA_XLEN-1:0]   imm;
        br_kind_t              br_kind;
        logic [`LA_XLEN-1:0]   br_offs;
        logic                  need_r1;
        logic                  need_r2;
        logic                  src2_is_rd;
        logic                  rf_we;
        logic [`LA_REG_AW-1:0] dest;
        logic                  mem_rd;
        logic                  mem_we;
        mem_size_t             mem_size;
        logic                  mem_unsigned;
    } dec_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic [`LA_XLEN-1:0]   alu_src1;
        logic [`LA_XLEN-1:0]   alu_src2;
        logic [`LA_XLEN-1:0]   rkd_value; // store data
        logic [`LA_XLEN-1:0]   pc;
        logic                  rf_we;
        logic [`LA_REG_AW-1:0] rf_waddr;
        logic                  mem_rd;
        logic                  mem_we;
        mem_size_t             mem_size;
        logic                  mem_unsigned;
    } id_ex_t;

    typedef struct packed {
        logic                taken;
        logic [`LA_XLEN-1:0] target;
        logic                stall;
    } br_t;

endpackage

`default_nettype wire

/* operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loong_id_params.svh"

module operand_forward
    import loong_id_pkg::*;
(
    input  logic [`LA_REG_AW-1:0] raddr1,
    input  logic [`LA_REG_AW-1:0] raddr2,
    input  logic                  need_r1,
    input  logic                  need_r2,
    input  logic [`LA_XLEN-1:0]   rdata1,
    input  logic [`LA_XLEN-1:0]   rdata2,
    input  fwd_t                  fwd_ex,
    input  fwd_t                  fwd_mem,
    input  rf_write_t             wb,
    output logic [`LA_XLEN-1:0]   rj_value,
    output logic [`LA_XLEN-1:0]   rkd_value,
    output logic                  stall
);

    logic r1_ex, r1_mem, r1_wb;
    logic r2_ex, r2_mem, r2_wb;

    function automatic logic hit(
        input logic                  need,
        input logic [`LA_REG_AW-1:0] addr,
        input rf_write_t             src
    );
        return need && (addr != '0) && src.we && (src.waddr == addr);
    endfunction

    assign r1_ex  = hit(need_r1, raddr1, fwd_ex.wr);
    assign r1_mem = hit(need_r1, raddr1, fwd_mem.wr);
    assign r1_wb  = hit(need_r1, raddr1, wb);
    assign r2_ex  = hit(need_r2, raddr2, fwd_ex.wr);
    assign r2_mem = hit(need_r2, raddr2, fwd_mem.wr);
    assign r2_wb  = hit(need_r2, raddr2, wb);

    // youngest producer wins
    assign rj_value  = r1_ex  ? fwd_ex.wr.wdata  :
                       r1_mem ? fwd_mem.wr.wdata :
                       r1_wb  ? wb.wdata         : rdata1;
    assign rkd_value = r2_ex  ? fwd_ex.wr.wdata  :
                       r2_mem ? fwd_mem.wr.wdata :
                       r2_wb  ? wb.wdata         : rdata2;

    // load results and other late data still in flight
    assign stall = ((r1_ex | r2_ex) & fwd_ex.late)
                 | ((r1_mem | r2_mem) & fwd_mem.late);

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loong_id_params.svh"

module regfile
    import loong_id_pkg::*;
(
    input  logic                  clk,
    input  logic [`LA_REG_AW-1:0] raddr1,
    input  logic [`LA_REG_AW-1:0] raddr2,
    output logic [`LA_XLEN-1:0]   rdata1,
    output logic [`LA_XLEN-1:0]   rdata2,
    input  rf_write_t             wr
);

    logic [`LA_XLEN-1:0] regs [`LA_NREG];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // r0 is hardwired zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loong_id_params.svh"

module tb_id_stage
    import loong_id_pkg::*;
();

    localparam int N_RR    = 30;
    localparam int N_IMM   = 30;
    localparam int N_FWD   = 12;
    localparam int N_STALL = 6;
    localparam int N_BR    = 30;
    localparam int N_BP    = 6;
    localparam int N_FLUSH = 3;
    localparam int N_TOTAL = N_RR + N_IMM + N_FWD + N_STALL + N_BR + N_BP + N_FLUSH;
    localparam int TIMEOUT = 20 * N_TOTAL;

    logic      clk;
    logic      resetn;
    logic      flush;
    logic      if_valid;
    if_id_t    if_id;
    logic      allowin;
    logic      ex_allowin;
    logic      ex_valid;
    id_ex_t    id_ex;
    fwd_t      fwd_ex;
    fwd_t      fwd_mem;
    rf_write_t wb;
    br_t       br;

    logic [`LA_XLEN-1:0]   model [`LA_NREG]; // mirror of the register file
    logic [31:0]           seed;
    logic                  chk;
    logic [`LA_INST_W-1:0] cur_inst;
    logic [`LA_XLEN-1:0]   cur_pc;
    int                    errors = 0;
    int                    checks = 0;
    int                    cycles = 0;
    logic [6:0]            rr_tab [11] = '{7'h20, 7'h22, 7'h24, 7'h25, 7'h28, 7'h29,
                                           7'h2a, 7'h2b, 7'h2e, 7'h2f, 7'h30};
    logic [9:0]            imm_tab [14] = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e,
                                            10'h00f, 10'h0a0, 10'h0a1, 10'h0a2, 10'h0a4,
                                            10'h0a5, 10'h0a6, 10'h0a8, 10'h0a9};

    id_stage u_dut (
        .clk        (clk),
        .resetn     (resetn),
        .flush      (flush),
        .if_valid   (if_valid),
        .if_id      (if_id),
        .allowin    (allowin),
        .ex_allowin (ex_allowin),
        .ex_valid   (ex_valid),
        .id_ex      (id_ex),
        .fwd_ex     (fwd_ex),
        .fwd_mem    (fwd_mem),
        .wb         (wb),
        .br         (br)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (wb.we) model[wb.waddr] <= wb.wdata;
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // operand as the stage should see it, youngest producer first
    function automatic logic [31:0] opv(input logic [4:0] a, input logic need);
        if (a == 5'd0) return '0;
        if (need && fwd_ex.wr.we && fwd_ex.wr.waddr == a) return fwd_ex.wr.wdata;
        if (need && fwd_mem.wr.we && fwd_mem.wr.waddr == a) return fwd_mem.wr.wdata;
        if (need && wb.we && wb.waddr == a) return wb.wdata;
        return model[a];
    endfunction

    function automatic logic is_late(input logic [4:0] a, input logic need);
        return need && a != 5'd0
            && ((fwd_ex.wr.we && fwd_ex.wr.waddr == a && fwd_ex.late)
             || (fwd_mem.wr.we && fwd_mem.wr.waddr == a && fwd_mem.late));
    endfunction

    function automatic void ref_model(input logic [31:0] inst, input logic [31:0] pc,
                                      output id_ex_t e, output br_t b, output logic st);
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  r2;
        logic [9:0]  op10;
        logic [5:0]  op6;
        logic [31:0] imm;
        logic [31:0] offs;
        logic [31:0] va;
        logic [31:0] vb;
        logic        sp;
        logic        si;
        logic        n1;
        logic        n2;
        logic        srd;
        logic        tk;
        br_kind_t    kind;
        int          op;
        rd = inst[4:0];
        rj = inst[9:5];
        op10 = inst[31:22];
        op6 = inst[31:26];
        e = '0;
        {sp, si, n1, n2, srd} = '0;
        imm = {{20{inst[21]}}, inst[21:10]};
        offs = {{14{inst[25]}}, inst[25:10], 2'b00};
        kind = BR_NONE;
        op = -1;
        e.mem_size = MEM_W;
        e.rf_waddr = rd;
        for (int k = 0; k < 11; k++) begin
            if (inst[31:15] == {10'h000, rr_tab[k]}) op = k;
        end
        if (op >= 0) begin
            e.alu_op[(op < 4) ? op : (op == 4) ? ALU_NOR : (op == 5) ? ALU_AND : op] = 1'b1;
            {n1, n2, e.rf_we} = 3'b111;
        end else if (inst[31:15] inside {17'h00081, 17'h00089, 17'h00091}) begin
            e.alu_op[inst[19] ? ALU_SRA : (inst[18] ? ALU_SRL : ALU_SLL)] = 1'b1;
            {si, n1, e.rf_we} = 3'b111;
        end else if (op10 inside {10'h008, 10'h009, 10'h00a}) begin
            e.alu_op[(op10 == 10'h008) ? ALU_SLT : (op10 == 10'h009) ? ALU_SLTU : ALU_ADD] = 1;
            {si, n1, e.rf_we} = 3'b111;
        end else if (op10 inside {10'h00d, 10'h00e, 10'h00f}) begin
            e.alu_op[(op10 == 10'h00d) ? ALU_AND : (op10 == 10'h00e) ? ALU_OR : ALU_XOR] = 1;
            {si, n1, e.rf_we} = 3'b111;
            imm = {20'b0, inst[21:10]}; // logic immediates zero-extend
        end else if (inst[31:25] == 7'h0a || inst[31:25] == 7'h0e) begin
            e.alu_op[(inst[31:25] == 7'h0a) ? ALU_LUI : ALU_ADD] = 1'b1;
            sp = inst[31:25] == 7'h0e;
            {si, e.rf_we} = 2'b11;
            imm = {inst[24:5], 12'b0};
        end else if (op10 inside {10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9,
                                  10'h0a4, 10'h0a5, 10'h0a6}) begin
            e.alu_op[ALU_ADD] = 1'b1;
            {si, n1} = 2'b11;
            e.mem_size = op10[0] ? MEM_H : (op10[1] ? MEM_W : MEM_B);
            e.mem_unsigned = op10[3];
            e.mem_we = op10[2];
            e.mem_rd = !op10[2];
            e.rf_we = !op10[2];
            {n2, srd} = {2{op10[2]}};
        end else if (op6 == 6'h13 || op6 == 6'h15) begin
            e.alu_op[ALU_ADD] = 1'b1;
            {sp, si, e.rf_we} = 3'b111;
            imm = 32'd4;
            n1 = op6 == 6'h13;
            kind = (op6 == 6'h13) ? BR_JIRL : BR_BL;
            if (op6 == 6'h15) e.rf_waddr = 5'd1;
        end else if (op6 == 6'h14) begin
            kind = BR_B;
        end else if (op6 inside {[6'h16:6'h1b]}) begin
            {n1, n2, srd} = 3'b111;
            kind = br_kind_t'(op6 - 6'h15);
        end
        if (kind inside {BR_B, BR_BL}) offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        r2 = srd ? rd : inst[14:10];
        va = opv(rj, n1);
        vb = opv(r2, n2);
        st = is_late(rj, n1) || is_late(r2, n2);
        e.alu_src1 = sp ? pc : va;
        e.alu_src2 = si ? imm : vb;
        e.rkd_value = vb;
        e.pc = pc;
        case (kind)
            BR_BEQ:  tk = va == vb;
            BR_BNE:  tk = va != vb;
            BR_BLT:  tk = $signed(va) < $signed(vb);
            BR_BGE:  tk = $signed(va) >= $signed(vb);
            BR_BLTU: tk = va < vb;
            BR_BGEU: tk = va >= vb;
            BR_NONE: tk = 1'b0;
            default: tk = 1'b1;
        endcase
        b.taken = tk && !st;
        b.stall = st && kind != BR_NONE;
        b.target = ((kind == BR_JIRL) ? va : pc) + offs;
    endfunction

    task automatic fail_line(input string what);
        $display("Fail at %0t: %s", $time, what);
        errors++;
    endtask

    always @(posedge clk) begin
        id_ex_t e;
        br_t    b;
        logic   st;
        if (chk) begin
            ref_model(cur_inst, cur_pc, e, b, st);
            checks++;
            assert (ex_valid == !st) else fail_line($sformatf("ex_valid %b for inst %h",
                                                              ex_valid, cur_inst));
            assert (st || id_ex == e) else fail_line($sformatf("id_ex %h, expected %h",
                                                               id_ex, e));
            assert (br.taken == b.taken && br.stall == b.stall)
                else fail_line($sformatf("br taken/stall %b%b for inst %h",
                                         br.taken, br.stall, cur_inst));
            assert (!b.taken || br.target == b.target)
                else fail_line($sformatf("target %h, expected %h", br.target, b.target));
            assert (allowin == ((!st && ex_allowin) || flush))
                else fail_line($sformatf("allowin %b for inst %h", allowin, cur_inst));
        end
    end

    // bp: cycles of ex_allowin low, shadow: offer a filler while the inst sits in decode
    task automatic run_inst(input logic [31:0] inst, input logic [31:0] pc, input int bp,
                            input bit shadow);
        int   n;
        logic done;
        logic tk;
        n = 0;
        @(negedge clk);
        if_valid = 1'b1;
        if_id = '{inst: inst, pc: pc};
        ex_allowin = (bp == 0);
        @(negedge clk);
        cur_inst = inst;
        cur_pc = pc;
        chk = 1'b1;
        if (shadow) if_id = '{inst: 32'h0280_0000, pc: pc + 4};
        else if_valid = 1'b0;
        do begin
            @(posedge clk);
            done = ex_valid && ex_allowin;
            tk = br.taken;
            @(negedge clk);
            n++;
            if (n >= bp) ex_allowin = 1'b1;
            if (n >= 3) begin
                fwd_ex.late = 1'b0; // producer finally has the value
                fwd_mem.late = 1'b0;
            end
        end while (!done);
        chk = 1'b0;
        if (shadow) begin
            if (tk) begin
                assert (!ex_valid) else fail_line("wrong-path inst reached execute");
            end
            if_valid = 1'b0;
            if (!tk) @(posedge clk);
        end
    endtask

    task automatic flush_inst(input logic [31:0] inst, input logic [31:0] pc);
        @(negedge clk);
        if_valid = 1'b1;
        if_id = '{inst: inst, pc: pc};
        ex_allowin = 1'b0;
        @(negedge clk);
        if_valid = 1'b0;
        cur_inst = inst;
        cur_pc = pc;
        chk = 1'b1;
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        chk = 1'b0;
        assert (!ex_valid) else fail_line("ex_valid still high after flush");
        ex_allowin = 1'b1;
    endtask

    task automatic end_test(input string name, input int e0, input int c0);
        $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] q;
        logic [31:0] inst;
        logic [4:0]  b;
        logic [4:0]  c;
        int          idx;
        int          e0;
        int          c0;
        resetn = 1'b0;
        flush = 1'b0;
        if_valid = 1'b0;
        if_id = '0;
        ex_allowin = 1'b1;
        fwd_ex = '0;
        fwd_mem = '0;
        wb = '0;
        chk = 1'b0;
        seed = 32'd61608;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        for (int k = 1; k < 32; k++) begin
            @(negedge clk);
            wb = '{we: 1'b1, waddr: 5'(k), wdata: lcg()};
        end
        @(negedge clk);
        wb = '0;

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_RR; i++) begin
            r = lcg();
            run_inst({10'h000, rr_tab[r[15:0] % 11], r[21:17], r[26:22], r[31:27]},
                     lcg() & 32'hffff_fffc, 0, 0);
        end
        end_test("alu_rr", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_IMM; i++) begin
            r = lcg();
            idx = r[15:0] % 19;
            if (idx < 14) inst = {imm_tab[idx], r[27:16], r[31:27], r[26:22]};
            else if (idx < 17) inst = {10'h001, 7'(8 * (idx - 14) + 1), r[20:16], r[31:22]};
            else inst = {(idx == 17) ? 7'h0a : 7'h0e, r[24:0]};
            run_inst(inst, lcg() & 32'hffff_fffc, 0, 0);
        end
        end_test("immediate", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_FWD; i++) begin
            r = lcg();
            b = (i % 4 == 0) ? 5'd0 : (r[26:22] | 5'd1); // r0 must never forward
            @(negedge clk);
            fwd_ex = '{wr: '{we: r[0], waddr: b, wdata: lcg()}, late: 1'b0};
            fwd_mem = '{wr: '{we: r[1], waddr: b, wdata: lcg()}, late: 1'b0};
            wb = '{we: r[2], waddr: b, wdata: lcg()};
            run_inst({17'h00020, r[21:17], b, r[31:27]}, lcg() & 32'hffff_fffc, 0, 0);
            fwd_ex = '0;
            fwd_mem = '0;
            wb = '0;
        end
        end_test("forward", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_STALL; i++) begin
            r = lcg();
            b = r[26:22] | 5'd1;
            @(negedge clk);
            if (i % 3 == 2) fwd_mem = '{wr: '{we: 1'b1, waddr: b, wdata: lcg()}, late: 1'b1};
            else fwd_ex = '{wr: '{we: 1'b1, waddr: b, wdata: lcg()}, late: 1'b1};
            inst = i[0] ? {17'h00020, r[21:17], b, r[31:27]} : {6'h16, r[15:0], b, r[31:27]};
            run_inst(inst, lcg() & 32'hffff_fffc, 0, 0);
            fwd_ex = '0;
            fwd_mem = '0;
        end
        end_test("late_stall", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_BR; i++) begin
            r = lcg();
            q = lcg();
            idx = r[15:0] % 9;
            b = r[26:22];
            c = r[0] ? b : r[31:27];
            if (idx < 6) inst = {6'(6'h16 + idx), q[15:0], b, c};
            else if (idx < 8) inst = {6'(6'h14 + idx - 6), q[15:0], q[25:16]};
            else inst = {6'h13, q[15:0], b, c};
            run_inst(inst, lcg() & 32'hffff_fffc, 0, 1);
        end
        end_test("branch", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_BP; i++) begin
            r = lcg();
            run_inst({10'h00a, r[27:16], r[26:22], r[31:27]}, lcg() & 32'hffff_fffc, 3, 0);
        end
        for (int i = 0; i < N_FLUSH; i++) begin
            r = lcg();
            flush_inst({10'h00e, r[27:16], r[26:22], r[31:27]}, lcg() & 32'hffff_fffc);
        end
        end_test("backpressure_flush", e0, c0);

        repeat (2) @(negedge clk);
        errors += u_dut.u_chk.fail_cnt;
        $display("total: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 u_dut.u_chk.fail_cnt);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
